// ==== build.f ====
+incdir+include
logic/harness_pkg.sv
logic/soc_rstgen.sv
logic/debug_req_gate.sv
logic/periph_demux.sv
logic/boot_rom.sv
logic/sram_mem.sv
logic/harness_top.sv
test/harness_checker.sv
test/harness_tb.sv

// ==== include/harness_params.svh ====
/*
 * Harness parameters
 * Bus widths, memory sizes, address map and the debug request
 * delay window shared by the SoC slice.
 */

`ifndef HARNESS_PARAMS_SVH
`define HARNESS_PARAMS_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define HARNESS_ADDR_W 32
`define HARNESS_DATA_W 64
`define HARNESS_BE_W 8

// --------------------------------------------------
// Address map and memory depths
// --------------------------------------------------
`define HARNESS_ROM_BASE 32'h0001_0000
`define HARNESS_ROM_WORDS 64
`define HARNESS_SRAM_BASE 32'h8000_0000
`define HARNESS_SRAM_WORDS 256

// Fixed data patterns
`define HARNESS_ROM_TAG 32'hB007_0000
`define HARNESS_ERR_RDATA 64'hDEAD_BEEF_DEAD_BEEF

// Boot window before the first debug request reaches the core
`define HARNESS_DMI_DEL_CYCLES 40

`endif

// ==== logic/boot_rom.sv ====
/*
 * Boot ROM
 * Fixed-content read-only memory. Each word carries a tag in the
 * upper half and its own index in the lower half.
 */

`timescale 1ns/100ps

`include "harness_params.svh"

module boot_rom (
  input  logic                       clk_i,
  input  harness_pkg::bus_req_t      req_i,
  output logic [`HARNESS_DATA_W-1:0] rdata_o
);

  localparam int unsigned off_w = $clog2(`HARNESS_BE_W);
  localparam int unsigned idx_w = $clog2(`HARNESS_ROM_WORDS);

  logic [idx_w-1:0]           word_idx;
  logic [`HARNESS_DATA_W-1:0] word_data;

  // Index wraps inside the ROM region
  assign word_idx = req_i.addr[off_w +: idx_w];

  // Content pattern, tag on top and index below
  assign word_data = {`HARNESS_ROM_TAG, {(32 - idx_w){1'b0}}, word_idx};

  // one-cycle read, we is ignored
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_o <= word_data;
    end
  end

endmodule

// ==== logic/debug_req_gate.sv ====
/*
 * Debug request gate
 * Keeps the core debug request low for a fixed window after
 * power-on reset so boot code can run, then applies the enable.
 */

`timescale 1ns/100ps

`include "harness_params.svh"

module debug_req_gate (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic debug_req_i,
  input  logic debug_en_i,
  output logic debug_req_o
);

  localparam int unsigned cnt_w = $clog2(`HARNESS_DMI_DEL_CYCLES + 1);

  logic [cnt_w-1:0] del_cnt_q;
  logic             window_open;

  // Counts down once per edge and parks at zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      del_cnt_q <= cnt_w'(`HARNESS_DMI_DEL_CYCLES);
    end else if (del_cnt_q != '0) begin
      del_cnt_q <= del_cnt_q - 1'b1;
    end
  end

  assign window_open = (del_cnt_q == '0);

  // No register on the request path, only the mask
  assign debug_req_o = window_open & debug_en_i & debug_req_i;

endmodule

// ==== logic/harness_pkg.sv ====
/*
 * Harness bus types
 * Single-beat request and response structs used between the
 * external master, the address demux and the memories.
 */

`include "harness_params.svh"

package harness_pkg;

  // One request per cycle with req high, no handshake
  typedef struct packed {
    logic                        req;
    logic                        we;
    logic [`HARNESS_ADDR_W-1:0]  addr;
    logic [`HARNESS_DATA_W-1:0]  wdata;
    logic [`HARNESS_BE_W-1:0]    be;
  } bus_req_t;

  // Response pulse one cycle after the request
  typedef struct packed {
    logic                        valid;
    logic                        err;
    logic [`HARNESS_DATA_W-1:0]  rdata;
  } bus_rsp_t;

endpackage

// ==== logic/harness_top.sv ====
/*
 * Harness top level
 * Reset generation, debug request gating and the bus slice with
 * address demux, boot ROM and SRAM.
 */

`timescale 1ns/100ps

`include "harness_params.svh"

module harness_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ndmreset_i,
  input  logic                  debug_req_i,
  input  logic                  debug_en_i,
  input  harness_pkg::bus_req_t bus_req_i,
  output harness_pkg::bus_rsp_t bus_rsp_o,
  output logic                  debug_req_o
);

  logic                       periph_rst_n;
  harness_pkg::bus_req_t      rom_req;
  harness_pkg::bus_req_t      sram_req;
  logic [`HARNESS_DATA_W-1:0] rom_rdata;
  logic [`HARNESS_DATA_W-1:0] sram_rdata;

  // --------------------------------------------------
  // Reset and debug
  // --------------------------------------------------
  soc_rstgen soc_rstgen_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .ndmreset_i (ndmreset_i),
    .rst_no     (periph_rst_n)
  );

  // Window runs on power-on reset only
  debug_req_gate debug_req_gate_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .debug_req_i (debug_req_i),
    .debug_en_i  (debug_en_i),
    .debug_req_o (debug_req_o)
  );

  // --------------------------------------------------
  // Bus slice
  // --------------------------------------------------
  periph_demux periph_demux_inst (
    .clk_i        (clk_i),
    .rst_ni       (periph_rst_n),
    .bus_req_i    (bus_req_i),
    .bus_rsp_o    (bus_rsp_o),
    .rom_req_o    (rom_req),
    .sram_req_o   (sram_req),
    .rom_rdata_i  (rom_rdata),
    .sram_rdata_i (sram_rdata)
  );

  boot_rom boot_rom_inst (
    .clk_i   (clk_i),
    .req_i   (rom_req),
    .rdata_o (rom_rdata)
  );

  sram_mem sram_mem_inst (
    .clk_i   (clk_i),
    .req_i   (sram_req),
    .rdata_o (sram_rdata)
  );

endmodule

// ==== logic/periph_demux.sv ====
/*
 * Peripheral demux
 * Decodes the request address, steers it to the boot ROM or the
 * SRAM, and returns one response per request a cycle later.
 */

`timescale 1ns/100ps

`include "harness_params.svh"

module periph_demux (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  harness_pkg::bus_req_t      bus_req_i,
  output harness_pkg::bus_rsp_t      bus_rsp_o,
  output harness_pkg::bus_req_t      rom_req_o,
  output harness_pkg::bus_req_t      sram_req_o,
  input  logic [`HARNESS_DATA_W-1:0] rom_rdata_i,
  input  logic [`HARNESS_DATA_W-1:0] sram_rdata_i
);

  localparam int unsigned word_bytes = `HARNESS_DATA_W / 8;
  localparam logic [`HARNESS_ADDR_W-1:0] rom_lo = `HARNESS_ROM_BASE;
  localparam logic [`HARNESS_ADDR_W-1:0] rom_hi =
    `HARNESS_ROM_BASE + `HARNESS_ROM_WORDS * word_bytes;
  localparam logic [`HARNESS_ADDR_W-1:0] sram_lo = `HARNESS_SRAM_BASE;
  localparam logic [`HARNESS_ADDR_W-1:0] sram_hi =
    `HARNESS_SRAM_BASE + `HARNESS_SRAM_WORDS * word_bytes;

  typedef enum logic [1:0] {
    tgt_rom,
    tgt_sram,
    tgt_none
  } tgt_e;

  logic rom_hit;
  logic sram_hit;
  tgt_e tgt_d;
  tgt_e tgt_q;
  logic valid_q;

  // --------------------------------------------------
  // Decode and steering
  // --------------------------------------------------
  assign rom_hit  = (bus_req_i.addr >= rom_lo) && (bus_req_i.addr < rom_hi);
  assign sram_hit = (bus_req_i.addr >= sram_lo) && (bus_req_i.addr < sram_hi);
  assign tgt_d    = rom_hit ? tgt_rom : (sram_hit ? tgt_sram : tgt_none);

  always_comb begin
    rom_req_o      = bus_req_i;
    rom_req_o.req  = bus_req_i.req & rom_hit;
    // ROM writes are answered like reads, data is dropped
    rom_req_o.we   = 1'b0;
    sram_req_o     = bus_req_i;
    sram_req_o.req = bus_req_i.req & sram_hit;
  end

  // Remember the target of the request in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tgt_q   <= tgt_none;
    end else begin
      valid_q <= bus_req_i.req;
      if (bus_req_i.req) begin
        tgt_q <= tgt_d;
      end
    end
  end

  // --------------------------------------------------
  // Response select
  // --------------------------------------------------
  always_comb begin
    bus_rsp_o.valid = valid_q;
    bus_rsp_o.err   = 1'b0;
    case (tgt_q)
      tgt_rom:  bus_rsp_o.rdata = rom_rdata_i;
      tgt_sram: bus_rsp_o.rdata = sram_rdata_i;
      default: begin
        bus_rsp_o.rdata = `HARNESS_ERR_RDATA;
        bus_rsp_o.err   = valid_q;
      end
    endcase
  end

endmodule

// ==== logic/soc_rstgen.sv ====
/*
 * Peripheral reset generator
 * Merges power-on reset with the debug-requested reset and
 * releases the result synchronously after two clock edges.
 */

`timescale 1ns/100ps

module soc_rstgen (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic ndmreset_i,
  output logic rst_no
);

  logic rst_comb_n;
  logic sync_q;

  // Either source holds the peripherals in reset
  assign rst_comb_n = rst_ni & ~ndmreset_i;

  always_ff @(posedge clk_i or negedge rst_comb_n) begin
    if (!rst_comb_n) begin
      sync_q <= 1'b0;
      rst_no <= 1'b0;
    end else begin
      sync_q <= 1'b1;
      rst_no <= sync_q;
    end
  end

endmodule

// ==== logic/sram_mem.sv ====
/*
 * Word SRAM
 * Single-port memory with per-byte write enables and a one-cycle
 * read that returns the word as it was before a write.
 */

`timescale 1ns/100ps

`include "harness_params.svh"

module sram_mem (
  input  logic                       clk_i,
  input  harness_pkg::bus_req_t      req_i,
  output logic [`HARNESS_DATA_W-1:0] rdata_o
);

  localparam int unsigned off_w = $clog2(`HARNESS_BE_W);
  localparam int unsigned idx_w = $clog2(`HARNESS_SRAM_WORDS);

  logic [`HARNESS_DATA_W-1:0] mem_q [`HARNESS_SRAM_WORDS];
  logic [idx_w-1:0]           word_idx;

  assign word_idx = req_i.addr[off_w +: idx_w];

  // --------------------------------------------------
  // Byte-masked write, read of the old word
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_o <= mem_q[word_idx];
      if (req_i.we) begin
        for (int b = 0; b < `HARNESS_BE_W; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the harness simulation with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

LOG=sim.log

verilator --binary --timing --assert --top-module harness_tb -f build.f -o harness_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/harness_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
exit 0

// ==== test/harness_checker.sv ====
/*
 * Harness checker
 * Concurrent assertions on the top level ports: one response
 * per earlier request, and no debug request without enable.
 */

`timescale 1ns/100ps

module harness_checker (
  input logic                  clk_i,
  input logic                  rst_ni,
  input harness_pkg::bus_req_t req_i,
  input harness_pkg::bus_rsp_t rsp_i,
  input logic                  dbg_en_i,
  input logic                  dbg_req_i
);

  // Response pulse must follow a request by exactly one cycle
  rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.valid |-> $past(req_i.req))
    else $error("Response valid without a request one cycle earlier");

  // Disabled debug never reaches the core
  dbg_needs_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_req_i |-> dbg_en_i)
    else $error("Debug request seen while debug enable is low");

endmodule

bind harness_top harness_checker harness_checker_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (bus_req_i),
  .rsp_i     (bus_rsp_o),
  .dbg_en_i  (debug_en_i),
  .dbg_req_i (debug_req_o)
);

// ==== test/harness_tb.sv ====
/*
 * Harness testbench
 * Runs the debug window, a table of ROM, SRAM and unmapped
 * accesses, the debug enable and an ndmreset pulse.
 */

`timescale 1ns/100ps

`include "harness_params.svh"

module harness_tb;

  typedef struct packed {
    logic        wr;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  be;
    logic [63:0] exp_rdata;
    logic        exp_err;
    logic        chk_rdata;
  } row_t;

  logic clk, rst_n, ndmreset, debug_req, debug_en, debug_req_out;
  harness_pkg::bus_req_t bus_req;
  harness_pkg::bus_rsp_t bus_rsp;

  row_t        rows [$];
  logic [63:0] sram_model [`HARNESS_SRAM_WORDS];
  bit          sram_known [`HARNESS_SRAM_WORDS];
  logic [31:0] lcg_state = 32'd98;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          timeout_limit = 1000;
  int          first_tail;

  harness_top harness_top_inst (
    .clk_i (clk), .rst_ni (rst_n), .ndmreset_i (ndmreset),
    .debug_req_i (debug_req), .debug_en_i (debug_en),
    .bus_req_i (bus_req), .bus_rsp_o (bus_rsp), .debug_req_o (debug_req_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("Timeout: run exceeded %0d cycles", timeout_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [63:0] merge_bytes(logic [63:0] old_w, logic [63:0] new_w,
                                             logic [7:0] be);
    logic [63:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Table with expected values from the address map
  // --------------------------------------------------
  task automatic add_row(input logic wr, input logic [31:0] addr, input logic [7:0] be);
    row_t r;
    int   idx;
    r = '0;
    r.wr = wr;
    r.addr = addr;
    r.be = be;
    r.chk_rdata = 1'b1;
    if (wr) begin
      r.wdata[63:32] = lcg_next();
      r.wdata[31:0]  = lcg_next();
    end
    if (addr >= `HARNESS_ROM_BASE && addr < `HARNESS_ROM_BASE + 32'(`HARNESS_ROM_WORDS * 8)) begin
      idx = int'((addr - `HARNESS_ROM_BASE) >> 3) % `HARNESS_ROM_WORDS;
      r.exp_rdata = {`HARNESS_ROM_TAG, 32'(idx)};
    end else if (addr >= `HARNESS_SRAM_BASE &&
                 addr < `HARNESS_SRAM_BASE + 32'(`HARNESS_SRAM_WORDS * 8)) begin
      idx = int'((addr - `HARNESS_SRAM_BASE) >> 3) % `HARNESS_SRAM_WORDS;
      // Response carries the word before the write
      r.exp_rdata = sram_model[idx];
      r.chk_rdata = sram_known[idx];
      if (wr) begin
        sram_model[idx] = merge_bytes(sram_model[idx], r.wdata, be);
        sram_known[idx] = sram_known[idx] || (be == 8'hFF);
      end
    end else begin
      r.exp_rdata = `HARNESS_ERR_RDATA;
      r.exp_err = 1'b1;
    end
    rows.push_back(r);
  endtask

  task automatic build_table();
    add_row(1'b1, 32'h8000_0000, 8'hFF);
    add_row(1'b1, 32'h8000_0008, 8'hFF);
    add_row(1'b1, 32'h8000_07F8, 8'hFF);
    add_row(1'b0, 32'h8000_0000, 8'h00);
    add_row(1'b0, 32'h8000_0008, 8'h00);
    add_row(1'b0, 32'h8000_07F8, 8'h00);
    add_row(1'b1, 32'h8000_0008, 8'h0F);
    add_row(1'b1, 32'h8000_0000, 8'hA5);
    add_row(1'b0, 32'h8000_0008, 8'h00);
    add_row(1'b0, 32'h8000_0000, 8'h00);
    add_row(1'b0, 32'h0001_0000, 8'h00);
    add_row(1'b0, 32'h0001_0008, 8'h00);
    add_row(1'b0, 32'h0001_0100, 8'h00);
    add_row(1'b0, 32'h0001_01F8, 8'h00);
    add_row(1'b1, 32'h0001_0008, 8'hFF);
    add_row(1'b0, 32'h0001_0008, 8'h00);
    add_row(1'b0, 32'h0000_0000, 8'h00);
    add_row(1'b0, 32'h0001_0200, 8'h00);
    add_row(1'b0, 32'h8000_0800, 8'h00);
    add_row(1'b1, 32'h4000_0000, 8'hFF);
    // Reads after the ndmreset pulse
    first_tail = rows.size();
    add_row(1'b0, 32'h8000_0000, 8'h00);
    add_row(1'b0, 32'h8000_0008, 8'h00);
    add_row(1'b0, 32'h8000_07F8, 8'h00);
  endtask

  // --------------------------------------------------
  // Drive and check
  // --------------------------------------------------
  task automatic drive_req(input logic req, input row_t r);
    bus_req.req = req;
    bus_req.we = r.wr;
    bus_req.addr = r.addr;
    bus_req.wdata = r.wdata;
    bus_req.be = r.be;
  endtask

  task automatic check_rsp(input row_t r);
    checks++;
    assert (bus_rsp.valid === 1'b1) else begin
      errors++;
      $display("ERROR bus_rsp_o.valid addr %h: got %h expected 1", r.addr, bus_rsp.valid);
    end
    assert (bus_rsp.err === r.exp_err) else begin
      errors++;
      $display("ERROR bus_rsp_o.err addr %h: got %h expected %h", r.addr, bus_rsp.err,
               r.exp_err);
    end
    assert (!r.chk_rdata || bus_rsp.rdata === r.exp_rdata) else begin
      errors++;
      $display("ERROR bus_rsp_o.rdata addr %h: got %h expected %h", r.addr, bus_rsp.rdata,
               r.exp_rdata);
    end
  endtask

  task automatic check_idle();
    checks++;
    assert (bus_rsp.valid === 1'b0) else begin
      errors++;
      $display("ERROR bus_rsp_o.valid: got %h expected 0 with no accepted request",
               bus_rsp.valid);
    end
  endtask

  task automatic check_debug(input logic expected);
    checks++;
    assert (debug_req_out === expected) else begin
      errors++;
      $display("ERROR debug_req_o at cycle %0d: got %h expected %h", cycle_cnt,
               debug_req_out, expected);
    end
  endtask

  // Rows go out back-to-back, each response checked a cycle later
  task automatic apply_rows(input int first, input int last);
    for (int i = first; i <= last + 1; i++) begin
      @(negedge clk);
      if (i > first) check_rsp(rows[i-1]);
      if (i <= last) drive_req(1'b1, rows[i]);
      else drive_req(1'b0, '0);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    ndmreset = 1'b0;
    debug_req = 1'b1;
    debug_en = 1'b1;
    bus_req = '0;
    build_table();
    timeout_limit = 10 + `HARNESS_DMI_DEL_CYCLES + 3 * rows.size() + 100;

    repeat (10) begin
      @(negedge clk);
      check_debug(1'b0);
    end
    rst_n = 1'b1;
    // Debug window counted from the release of rst_ni
    for (int c = 1; c <= `HARNESS_DMI_DEL_CYCLES; c++) begin
      @(negedge clk);
      check_debug(c == `HARNESS_DMI_DEL_CYCLES);
      check_idle();
    end

    apply_rows(0, first_tail - 1);

    @(negedge clk);
    debug_en = 1'b0;
    @(negedge clk);
    check_debug(1'b0);
    debug_en = 1'b1;
    @(negedge clk);
    check_debug(1'b1);

    // ndmreset pulse with requests that must be dropped
    ndmreset = 1'b1;
    drive_req(1'b1, rows[first_tail]);
    @(negedge clk);
    check_idle();
    check_debug(1'b1);
    @(negedge clk);
    check_idle();
    drive_req(1'b0, '0);
    ndmreset = 1'b0;
    repeat (2) @(negedge clk);
    check_idle();
    check_debug(1'b1);
    apply_rows(first_tail, rows.size() - 1);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
